//--- Bender.yml
package:
  name: regfile

sources:
  - design/regfile_pkg.sv
  - design/byte_position_counters.sv
  - design/dataset_reader.sv
  - design/readout_fifo.sv
  - design/cmd_credit_queue.sv
  - design/reg_bank.sv
  - design/regfile_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/regfile_asserts.sv
      - testbench/tb_regfile.sv

//--- all.f
design/regfile_pkg.sv
design/byte_position_counters.sv
design/dataset_reader.sv
design/readout_fifo.sv
design/cmd_credit_queue.sv
design/reg_bank.sv
design/regfile_top.sv
testbench/tb_clock.sv
testbench/regfile_asserts.sv
testbench/tb_regfile.sv

//--- testbench/tb_regfile.sv
module tb_regfile import regfile_pkg::*; ();

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PUSH, OP_CREDIT, OP_PORTS} op_e;

    typedef struct packed {
        logic [3:0]  test;
        op_e         op;
        logic [7:0]  addr;
        logic [63:0] data;
        logic [7:0]  expected;
    } step_t;

    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] LFSR_SEED    = 32'h43f7baab;

    logic                          clk;
    logic                          reset;
    bus_req_t                      bus_req;
    logic [DATA_W-1:0]             read_data;
    logic                          done;
    readout_word_t                 word_in;
    logic                          fifo_full;
    chip_config_t                  chip_config;
    trigger_config_t               trigger_config;
    logic [DATA_W*IP_BYTES-1:0]    eth_ip;
    logic [DATA_W*DELAY_BYTES-1:0] trigger_delay;
    cmd_byte_t                     cmd_out;
    logic                          cmd_credit;

    step_t       stimulus[$];
    string       test_names[1:5];
    logic [3:0]  current_test;
    logic [31:0] lfsr_state;
    logic [7:0]  cmd_expected[$];
    logic [7:0]  cmd_received[$];
    logic [7:0]  cmd_dropped;
    int          credits_returned;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_failed;
    int          cycles;
    int          cycle_limit;

    tb_clock tb_clock_inst (.clk(clk));

    regfile_top regfile_top_inst (
        .clk            (clk),
        .reset          (reset),
        .bus_req        (bus_req),
        .read_data      (read_data),
        .done           (done),
        .word_in        (word_in),
        .fifo_full      (fifo_full),
        .chip_config    (chip_config),
        .trigger_config (trigger_config),
        .eth_ip         (eth_ip),
        .trigger_delay  (trigger_delay),
        .cmd_out        (cmd_out),
        .cmd_credit     (cmd_credit)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic make_word(output logic [63:0] w);
        int i;
        w = '0;
        for (i = 0; i < 64; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[62:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic add_step(input op_e op, input logic [7:0] addr, input logic [63:0] data,
                            input logic [7:0] exp);
        stimulus.push_back('{current_test, op, addr, data, exp});
    endtask

    task automatic build_stimulus();
        logic [63:0] words[FIFO_DEPTH];
        int i;
        int w;
        current_test = 1;
        add_step(OP_PORTS, ETH_IP, {8'd192, 8'd168, 8'd1, 8'd128}, 0);
        add_step(OP_READ, CHIP_CONFIG, 0, 8'h00);
        add_step(OP_READ, TRIG_CONFIG, 0, 8'h10);
        add_step(OP_READ, ETH_IP, 0, 8'd192);
        add_step(OP_READ, ETH_IP, 0, 8'd168);
        add_step(OP_READ, ETH_IP, 0, 8'd1);
        add_step(OP_READ, ETH_IP, 0, 8'd128);
        add_step(OP_WRITE, TEST_ID, 8'h55, 0);
        add_step(OP_READ, TEST_ID, 0, 8'hAB);
        add_step(OP_READ, 8'd99, 0, 8'h00);
        current_test = 2;
        add_step(OP_WRITE, CHIP_CONFIG, 8'h0B, 0);
        add_step(OP_READ, CHIP_CONFIG, 0, 8'h0B);
        add_step(OP_PORTS, CHIP_CONFIG, 0, 8'h0B);
        add_step(OP_WRITE, TRIG_CONFIG, 8'hA7, 0);
        add_step(OP_READ, TRIG_CONFIG, 0, 8'hA7);
        add_step(OP_PORTS, TRIG_CONFIG, 0, 8'hA7);
        current_test = 3;
        add_step(OP_WRITE, TRIG_DELAY, 8'h12, 0);
        add_step(OP_WRITE, TRIG_DELAY, 8'h34, 0);
        add_step(OP_WRITE, TRIG_DELAY, 8'h56, 0);
        add_step(OP_PORTS, TRIG_DELAY, 64'h123456, 0);
        add_step(OP_READ, TRIG_DELAY, 0, 8'h12);
        add_step(OP_READ, TRIG_DELAY, 0, 8'h34);
        add_step(OP_READ, TRIG_DELAY, 0, 8'h56);
        add_step(OP_READ, TRIG_DELAY, 0, 8'h12);
        // Fill the FIFO, peek at the status mid-dataset, then read one empty dataset
        current_test = 4;
        for (w = 0; w < FIFO_DEPTH; w++) begin
            make_word(words[w]);
            add_step(OP_PUSH, 0, words[w], 0);
        end
        add_step(OP_PORTS, READOUT_STATUS, 0, 8'h0A);
        add_step(OP_READ, READOUT_STATUS, 0, 8'h0A);
        for (w = 0; w < FIFO_DEPTH; w++) begin
            for (i = 0; i < DATASET_BYTES; i++) begin
                if (w == 0 && i == 3) begin
                    add_step(OP_READ, READOUT_STATUS, 0, 8'h00);
                end
                add_step(OP_READ, READOUT_DATA, 0, words[w][63-8*i -: 8]);
            end
        end
        add_step(OP_READ, READOUT_STATUS, 0, 8'h09);
        add_step(OP_PORTS, READOUT_STATUS, 0, 8'h09);
        for (i = 0; i < DATASET_BYTES; i++) begin
            add_step(OP_READ, READOUT_DATA, 0, 8'hFF);
        end
        add_step(OP_READ, READOUT_STATUS, 0, 8'h09);
        // Credits drain two bytes, then the queue fills and the next byte overflows
        current_test = 5;
        for (i = 0; i < CMD_CREDITS + CMD_DEPTH; i++) begin
            add_step(OP_WRITE, CMD_DATA, 8'hC0 + i, 0);
            cmd_expected.push_back(8'hC0 + i);
        end
        cmd_dropped = 8'hC0 + CMD_CREDITS + CMD_DEPTH;
        add_step(OP_WRITE, CMD_DATA, cmd_dropped, 0);
        add_step(OP_READ, CMD_STATUS, 0, 8'hC0 | CMD_DEPTH);
        add_step(OP_CREDIT, 0, 0, 0);
        add_step(OP_CREDIT, 0, 0, 0);
        add_step(OP_READ, CMD_STATUS, 0, 8'h80 | (CMD_DEPTH - 2));
        add_step(OP_CREDIT, 0, 0, 0);
        add_step(OP_CREDIT, 0, 0, 0);
        add_step(OP_READ, CMD_STATUS, 0, 8'h80);
    endtask

    // ------------------------------
    // Driving one table entry
    // ------------------------------
    task automatic apply_step(input step_t s);
        case (s.op)
            OP_WRITE, OP_READ: begin
                @(posedge clk);
                bus_req <= '{read: s.op == OP_READ, write: s.op == OP_WRITE,
                             address: s.addr, write_data: s.data[7:0]};
                @(posedge clk);
                bus_req <= '0;
                @(negedge clk);
                if (s.op == OP_READ) begin
                    while (done !== 1'b1) begin
                        @(negedge clk);
                    end
                    check(read_data, s.expected, $sformatf("read of address %0d", s.addr));
                end else begin
                    check(done, 1'b0, "done after a write");
                end
            end
            OP_PUSH: begin
                @(negedge clk);
                while (fifo_full) begin
                    @(negedge clk);
                end
                @(posedge clk);
                word_in <= '{valid: 1'b1, data: s.data};
                @(posedge clk);
                word_in <= '0;
            end
            OP_CREDIT: begin
                @(posedge clk);
                cmd_credit <= 1'b1;
                credits_returned++;
                @(posedge clk);
                cmd_credit <= 1'b0;
            end
            default: begin
                @(negedge clk);
                case (s.addr)
                    CHIP_CONFIG: begin
                        check(chip_config.clock1, s.expected[0], "chip_config.clock1");
                        check(chip_config.clock2, s.expected[1], "chip_config.clock2");
                        check(chip_config.data, s.expected[2], "chip_config.data");
                        check(chip_config.load, s.expected[3], "chip_config.load");
                    end
                    TRIG_CONFIG: begin
                        check(trigger_config.trig_edge, s.expected[0], "trigger edge");
                        check(trigger_config.ftdi_trigger, s.expected[1],
                              "trigger ftdi_trigger");
                        check(trigger_config.source, s.expected[4:2], "trigger source");
                        check(trigger_config.noise_suppression, s.expected[7:5],
                              "trigger noise_suppression");
                    end
                    ETH_IP: check(eth_ip, s.data[31:0], "eth_ip");
                    READOUT_STATUS: check(fifo_full, s.expected[1], "fifo_full");
                    default: check(trigger_delay, s.data[23:0], "trigger_delay");
                endcase
            end
        endcase
    endtask

    task automatic finish_test(input logic [3:0] n);
        int i;
        if (n == 5) begin
            check(cmd_received.size(), cmd_expected.size(), "bytes seen on cmd_out");
            check(cmd_received.size() <= CMD_CREDITS + credits_returned, 1'b1,
                  "cmd_out bytes within credits");
            for (i = 0; i < cmd_received.size(); i++) begin
                if (i < cmd_expected.size()) begin
                    check(cmd_received[i], cmd_expected[i], $sformatf("cmd_out byte %0d", i));
                end
                check(cmd_received[i] != cmd_dropped, 1'b1, "overflowed byte on cmd_out");
            end
        end
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d errors", n, test_names[n],
                 (test_errors == 0) ? "passed" : "failed", test_errors);
    endtask

    // Collect every byte the queue sends
    always @(negedge clk) begin
        if (reset === 1'b0 && cmd_out.valid === 1'b1) begin
            cmd_received.push_back(cmd_out.data);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        reset      <= 1'b1;
        bus_req    <= '0;
        word_in    <= '0;
        cmd_credit <= 1'b0;
        lfsr_state = LFSR_SEED;
        checks = 0;
        errors = 0;
        tests_failed = 0;
        credits_returned = 0;
        cycles = 0;
        cycle_limit = 0;
        test_names[1] = "reset values";
        test_names[2] = "plain registers";
        test_names[3] = "multi-byte registers";
        test_names[4] = "readout datasets";
        test_names[5] = "command credits";
        build_stimulus();
        cycle_limit = 10 * stimulus.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < stimulus.size(); i++) begin
            if (i == 0 || stimulus[i].test != stimulus[i-1].test) begin
                test_errors = 0;
            end
            apply_step(stimulus[i]);
            if (i == stimulus.size() - 1 || stimulus[i+1].test != stimulus[i].test) begin
                finish_test(stimulus[i].test);
            end
        end
        errors += regfile_top_inst.regfile_asserts_inst.fail_count;
        $display("Summary: 5 tests, %0d failed, %0d checks, %0d errors",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/regfile_asserts.sv
module regfile_asserts import regfile_pkg::*; (
    input logic          clk,
    input logic          reset,
    input bus_req_t      bus_req,
    input logic          done,
    input readout_word_t word_in,
    input logic          fifo_full,
    input cmd_byte_t     cmd_out,
    input logic          cmd_credit
);

    int credit_mirror;
    int fail_count = 0;

    // Credits the decoder has handed out, minus bytes already seen on cmd_out
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_mirror <= CMD_CREDITS;
        end else begin
            credit_mirror <= credit_mirror + int'(cmd_credit) - int'(cmd_out.valid);
        end
    end

    // ------------------------------
    done_after_read: assert property (@(posedge clk) disable iff (reset)
        bus_req.read |=> done)
        else begin
            $error("done did not follow a read by one cycle");
            fail_count++;
        end

    done_only_after_read: assert property (@(posedge clk) disable iff (reset)
        !bus_req.read |=> !done)
        else begin
            $error("done high after a cycle without read");
            fail_count++;
        end

    no_push_while_full: assert property (@(posedge clk) disable iff (reset)
        !(word_in.valid && fifo_full))
        else begin
            $error("producer word offered while the FIFO is full");
            fail_count++;
        end

    cmd_within_credit: assert property (@(posedge clk) disable iff (reset)
        cmd_out.valid |-> credit_mirror > 0)
        else begin
            $error("command byte sent without an available credit");
            fail_count++;
        end

endmodule

bind regfile_top regfile_asserts regfile_asserts_inst (
    .clk        (clk),
    .reset      (reset),
    .bus_req    (bus_req),
    .done       (done),
    .word_in    (word_in),
    .fifo_full  (fifo_full),
    .cmd_out    (cmd_out),
    .cmd_credit (cmd_credit)
);

//--- testbench/tb_clock.sv
module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 4;

    // Free running, 8 time units per cycle
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

//--- design/regfile_top.sv
module regfile_top import regfile_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  bus_req_t                         bus_req,
    output logic [DATA_W-1:0]                read_data,
    output logic                             done,
    input  readout_word_t                    word_in,
    output logic                             fifo_full,
    output chip_config_t                     chip_config,
    output trigger_config_t                  trigger_config,
    output logic [DATA_W*IP_BYTES-1:0]       eth_ip,
    output logic [DATA_W*DELAY_BYTES-1:0]    trigger_delay,
    output cmd_byte_t                        cmd_out,
    input  logic                             cmd_credit
);

    read_pos_t                    read_pos;
    logic                         ip_step;
    logic                         delay_step;
    logic                         dataset_read;
    logic [DATA_W-1:0]            dataset_byte;
    logic                         dataset_start;
    logic                         fifo_pop;
    logic [WORD_W-1:0]            fifo_head;
    logic                         fifo_empty;
    logic                         cmd_push;
    logic [DATA_W-1:0]            cmd_push_data;
    logic [$clog2(CMD_DEPTH):0]   cmd_count;
    logic                         cmd_full;
    logic                         cmd_overflow;

    reg_bank reg_bank_inst (
        .clk            (clk),
        .reset          (reset),
        .bus_req        (bus_req),
        .read_data      (read_data),
        .done           (done),
        .read_pos       (read_pos),
        .ip_step        (ip_step),
        .delay_step     (delay_step),
        .dataset_read   (dataset_read),
        .dataset_byte   (dataset_byte),
        .dataset_start  (dataset_start),
        .fifo_empty     (fifo_empty),
        .fifo_full      (fifo_full),
        .cmd_push       (cmd_push),
        .cmd_push_data  (cmd_push_data),
        .cmd_count      (cmd_count),
        .cmd_full       (cmd_full),
        .cmd_overflow   (cmd_overflow),
        .chip_config    (chip_config),
        .trigger_config (trigger_config),
        .eth_ip         (eth_ip),
        .trigger_delay  (trigger_delay)
    );

    byte_position_counters byte_position_counters_inst (
        .clk        (clk),
        .reset      (reset),
        .ip_step    (ip_step),
        .delay_step (delay_step),
        .read_pos   (read_pos)
    );

    dataset_reader dataset_reader_inst (
        .clk           (clk),
        .reset         (reset),
        .dataset_read  (dataset_read),
        .fifo_head     (fifo_head),
        .fifo_empty    (fifo_empty),
        .fifo_pop      (fifo_pop),
        .dataset_byte  (dataset_byte),
        .dataset_start (dataset_start)
    );

    readout_fifo readout_fifo_inst (
        .clk     (clk),
        .reset   (reset),
        .word_in (word_in),
        .pop     (fifo_pop),
        .head    (fifo_head),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    cmd_credit_queue cmd_credit_queue_inst (
        .clk        (clk),
        .reset      (reset),
        .push       (cmd_push),
        .push_data  (cmd_push_data),
        .cmd_out    (cmd_out),
        .cmd_credit (cmd_credit),
        .count      (cmd_count),
        .full       (cmd_full),
        .overflow   (cmd_overflow)
    );

endmodule

//--- design/reg_bank.sv
module reg_bank import regfile_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  bus_req_t                         bus_req,
    output logic [DATA_W-1:0]                read_data,
    output logic                             done,
    input  read_pos_t                        read_pos,
    output logic                             ip_step,
    output logic                             delay_step,
    output logic                             dataset_read,
    input  logic [DATA_W-1:0]                dataset_byte,
    input  logic                             dataset_start,
    input  logic                             fifo_empty,
    input  logic                             fifo_full,
    output logic                             cmd_push,
    output logic [DATA_W-1:0]                cmd_push_data,
    input  logic [$clog2(CMD_DEPTH):0]       cmd_count,
    input  logic                             cmd_full,
    input  logic                             cmd_overflow,
    output chip_config_t                     chip_config,
    output trigger_config_t                  trigger_config,
    output logic [DATA_W*IP_BYTES-1:0]       eth_ip,
    output logic [DATA_W*DELAY_BYTES-1:0]    trigger_delay
);

    logic [DATA_W-1:0]              chip_config_reg;
    trigger_config_t                trigger_config_reg;
    logic [DATA_W*IP_BYTES-1:0]     eth_ip_reg;
    logic [DATA_W*DELAY_BYTES-1:0]  trigger_delay_reg;
    logic [DATA_W-1:0]              ip_byte;
    logic [DATA_W-1:0]              delay_byte;

    // ------------------------------
    // Strobes to the helper blocks
    // ------------------------------
    assign ip_step       = bus_req.read  && (bus_req.address == ETH_IP);
    assign delay_step    = bus_req.read  && (bus_req.address == TRIG_DELAY);
    assign dataset_read  = bus_req.read  && (bus_req.address == READOUT_DATA);
    assign cmd_push      = bus_req.write && (bus_req.address == CMD_DATA);
    assign cmd_push_data = bus_req.write_data;

    assign chip_config    = chip_config_reg[3:0];
    assign trigger_config = trigger_config_reg;
    assign eth_ip         = eth_ip_reg;
    assign trigger_delay  = trigger_delay_reg;

    // Most significant byte sits at position 0
    assign ip_byte    = eth_ip_reg[DATA_W*(IP_BYTES-1-int'(read_pos.ip_pos)) +: DATA_W];
    assign delay_byte =
        trigger_delay_reg[DATA_W*(DELAY_BYTES-1-int'(read_pos.delay_pos)) +: DATA_W];

    // ------------------------------
    // Write decode
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            chip_config_reg    <= '0;
            trigger_config_reg <= TRIG_CONFIG_RESET;
            eth_ip_reg         <= IP_RESET;
            trigger_delay_reg  <= '0;
        end else if (bus_req.write) begin
            case (bus_req.address)
                CHIP_CONFIG: chip_config_reg    <= bus_req.write_data;
                TRIG_CONFIG: trigger_config_reg <= bus_req.write_data;
                // Shift in from the low end
                ETH_IP: begin
                    eth_ip_reg <= {eth_ip_reg[DATA_W*(IP_BYTES-1)-1:0], bus_req.write_data};
                end
                TRIG_DELAY: begin
                    trigger_delay_reg <=
                        {trigger_delay_reg[DATA_W*(DELAY_BYTES-1)-1:0], bus_req.write_data};
                end
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= bus_req.read;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req.read) begin
            case (bus_req.address)
                CHIP_CONFIG:    read_data <= chip_config_reg;
                READOUT_STATUS: read_data <= {4'b0, dataset_start, 1'b0, fifo_full, fifo_empty};
                READOUT_DATA:   read_data <= dataset_byte;
                ETH_IP:         read_data <= ip_byte;
                TRIG_CONFIG:    read_data <= trigger_config_reg;
                TRIG_DELAY:     read_data <= delay_byte;
                CMD_STATUS:     read_data <= {cmd_overflow, cmd_full, 3'b0, cmd_count};
                TEST_ID:        read_data <= TEST_ID_VALUE;
                default:        read_data <= '0;
            endcase
        end
    end

endmodule

//--- design/cmd_credit_queue.sv
module cmd_credit_queue import regfile_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        push,
    input  logic [DATA_W-1:0]           push_data,
    output cmd_byte_t                   cmd_out,
    input  logic                        cmd_credit,
    output logic [$clog2(CMD_DEPTH):0]  count,
    output logic                        full,
    output logic                        overflow
);

    typedef logic [$clog2(CMD_DEPTH):0]     ptr_t;
    typedef logic [$clog2(CMD_CREDITS+1)-1:0] credit_t;

    logic [DATA_W-1:0]  mem [CMD_DEPTH];
    ptr_t               wr_ptr;
    ptr_t               rd_ptr;
    credit_t            credits;
    logic               send;
    logic               out_valid;
    logic [DATA_W-1:0]  out_data;

    assign count = wr_ptr - rd_ptr;
    assign full  = (count == ptr_t'(CMD_DEPTH));

    // Head byte goes out while the decoder still has room
    assign send = (count != '0) && (credits != '0);

    assign cmd_out.valid = out_valid;
    assign cmd_out.data  = out_data;

    // ------------------------------
    // Pointers, credits, overflow
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            credits   <= credit_t'(CMD_CREDITS);
            overflow  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            if (push && !full) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (push && full) begin
                overflow <= 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            case ({send, cmd_credit})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr[$clog2(CMD_DEPTH)-1:0]] <= push_data;
        end
        if (send) begin
            out_data <= mem[rd_ptr[$clog2(CMD_DEPTH)-1:0]];
        end
    end

endmodule

//--- design/readout_fifo.sv
module readout_fifo import regfile_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  readout_word_t      word_in,
    input  logic               pop,
    output logic [WORD_W-1:0]  head,
    output logic               empty,
    output logic               full
);

    // One extra pointer bit tells full from empty
    typedef logic [$clog2(FIFO_DEPTH):0] ptr_t;

    logic [WORD_W-1:0]  mem [FIFO_DEPTH];
    ptr_t               wr_ptr;
    ptr_t               rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[$clog2(FIFO_DEPTH)] != rd_ptr[$clog2(FIFO_DEPTH)])
                && (wr_ptr[$clog2(FIFO_DEPTH)-1:0] == rd_ptr[$clog2(FIFO_DEPTH)-1:0]);

    assign do_push = word_in.valid && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr[$clog2(FIFO_DEPTH)-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[$clog2(FIFO_DEPTH)-1:0]] <= word_in.data;
        end
    end

endmodule

//--- design/dataset_reader.sv
module dataset_reader import regfile_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               dataset_read,
    input  logic [WORD_W-1:0]  fifo_head,
    input  logic               fifo_empty,
    output logic               fifo_pop,
    output logic [DATA_W-1:0]  dataset_byte,
    output logic               dataset_start
);

    typedef logic [$clog2(DATASET_BYTES)-1:0] index_t;

    dataset_state_e     state;
    index_t             byte_index;
    logic [WORD_W-1:0]  word;

    assign dataset_start = (state == IDLE_START);

    // Pop on the first byte, only when a word is there
    assign fifo_pop = dataset_read && dataset_start && !fifo_empty;

    always_comb begin
        case (state)
            IDLE_START:  dataset_byte = fifo_empty ? PAD_BYTE : fifo_head[WORD_W-1 -: DATA_W];
            STREAM_WORD: dataset_byte =
                word[DATA_W*(DATASET_BYTES-1-int'(byte_index)) +: DATA_W];
            default:     dataset_byte = PAD_BYTE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE_START;
            byte_index <= '0;
        end else if (dataset_read) begin
            if (state == IDLE_START) begin
                state      <= fifo_empty ? STREAM_PAD : STREAM_WORD;
                byte_index <= index_t'(1);
            end else if (byte_index == index_t'(DATASET_BYTES - 1)) begin
                state      <= IDLE_START;
                byte_index <= '0;
            end else begin
                byte_index <= byte_index + index_t'(1);
            end
        end
    end

    // Latched head word for bytes 6 down to 0
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            word <= fifo_head;
        end
    end

endmodule

//--- design/byte_position_counters.sv
module byte_position_counters import regfile_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ip_step,
    input  logic      delay_step,
    output read_pos_t read_pos
);

    // Step a position, wrap back to the first byte after the last one
    function automatic logic [1:0] next_pos(input logic [1:0] pos, input int bytes);
        logic [1:0] result;
        if (pos == 2'(bytes - 1)) begin
            result = 2'd0;
        end else begin
            result = pos + 2'd1;
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            read_pos <= '0;
        end else begin
            if (ip_step) begin
                read_pos.ip_pos <= next_pos(read_pos.ip_pos, IP_BYTES);
            end
            if (delay_step) begin
                read_pos.delay_pos <= next_pos(read_pos.delay_pos, DELAY_BYTES);
            end
        end
    end

endmodule

//--- design/regfile_pkg.sv
package regfile_pkg;

    // ------------------------------
    // Widths and sizes
    // ------------------------------
    localparam int DATA_W        = 8;
    localparam int WORD_W        = 64;
    localparam int DATASET_BYTES = 8;
    localparam int FIFO_DEPTH    = 8;
    localparam int CMD_DEPTH     = 4;
    localparam int CMD_CREDITS   = 2;
    localparam int IP_BYTES      = 4;
    localparam int DELAY_BYTES   = 3;

    // Reset and constant register values
    localparam logic [DATA_W*IP_BYTES-1:0] IP_RESET = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [DATA_W-1:0] TRIG_CONFIG_RESET = 8'h10;
    localparam logic [DATA_W-1:0] TEST_ID_VALUE     = 8'hAB;
    localparam logic [DATA_W-1:0] PAD_BYTE          = 8'hFF;

    // ------------------------------
    // Register map
    // ------------------------------
    typedef enum logic [7:0] {
        CHIP_CONFIG    = 8'd0,
        READOUT_STATUS = 8'd10,
        READOUT_DATA   = 8'd11,
        ETH_IP         = 8'd30,
        TRIG_CONFIG    = 8'd40,
        TRIG_DELAY     = 8'd41,
        CMD_STATUS     = 8'd50,
        CMD_DATA       = 8'd51,
        TEST_ID        = 8'd80
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE_START,
        STREAM_WORD,
        STREAM_PAD
    } dataset_state_e;

    // Host request whose address stays a raw byte so unmapped values pass through
    typedef struct packed {
        logic                          read;
        logic                          write;
        logic [$bits(reg_addr_e)-1:0]  address;
        logic [DATA_W-1:0]             write_data;
    } bus_req_t;

    // Bits 3 down to 0 of register 0
    typedef struct packed {
        logic load;
        logic data;
        logic clock2;
        logic clock1;
    } chip_config_t;

    typedef struct packed {
        logic [2:0] noise_suppression;
        logic [2:0] source;
        logic       ftdi_trigger;
        logic       trig_edge;
    } trigger_config_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } readout_word_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } cmd_byte_t;

    typedef struct packed {
        logic [1:0] ip_pos;
        logic [1:0] delay_pos;
    } read_pos_t;

endpackage
